// File: dev_status.f
logic/dev_st_pkg.sv
logic/tts_counter.sv
logic/link_status_monitor.sv
logic/status_scheduler.sv
logic/status_record_tx.sv
logic/dev_status_top.sv
testbench/tb_dev_status.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dev_status -f dev_status.f

./obj_dir/Vtb_dev_status | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  exit 0
fi
exit 1

// File: testbench/tb_dev_status.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dev_status;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int ENC_CYCLES   = 40;
  localparam int GAP_CYCLES   = 100;  // lets a record drain before the next event
  localparam int REC_COUNT    = 8;    // records produced by the sequence below
  localparam int TEST_CYCLES  = RESET_CYCLES + ENC_CYCLES + 4 * GAP_CYCLES
    + 3 * (dev_st_pkg::ST_INTERVAL_CNT + 1) + 3 * (dev_st_pkg::ST_DELAY_CNT + 5)
    + dev_st_pkg::ST_FORCE_CNT + 8;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;

  logic dev_st_clk;
  logic sys_reset_in;
  logic [dev_st_pkg::SN_WIDTH-1:0] dev_sn;
  logic cfg_capture_en;
  logic mg_join;
  logic force_resend;
  logic [dev_st_pkg::PHY_COUNT-1:0] link_ready;
  logic [dev_st_pkg::PHY_COUNT-1:0] link_1g;
  logic [dev_st_pkg::PHY_COUNT-1:0] link_100m;
  dev_st_pkg::link_st_t [dev_st_pkg::PHY_COUNT-1:0] link_st;
  logic capture_en;
  logic [dev_st_pkg::TTS_WIDTH-1:0] tts_uint;
  logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] tts_gray;
  logic st_byte_valid;
  logic [dev_st_pkg::BYTE_WIDTH-1:0] st_byte;
  logic st_byte_first;
  logic st_byte_last;

  int cyc;
  int mark;       // cycle of the last reference event
  int rec_count;
  int rec_idx;
  logic rst_q;    // reset as seen at the last rising edge
  logic [31:0] lfsr;
  logic [dev_st_pkg::TTS_WIDTH-1:0] prev_tts;
  logic [dev_st_pkg::TTS_WIDTH-1:0] rec_tts;
  dev_st_pkg::st_record_u got_rec;

  dev_status_top dut (
    .dev_st_clk       (dev_st_clk),
    .sys_reset_in     (sys_reset_in),
    .dev_sn_i         (dev_sn),
    .cfg_capture_en_i (cfg_capture_en),
    .mg_join_i        (mg_join),
    .force_resend_i   (force_resend),
    .link_ready_i     (link_ready),
    .link_1g_i        (link_1g),
    .link_100m_i      (link_100m),
    .link_st_o        (link_st),
    .capture_en_o     (capture_en),
    .tts_uint_o       (tts_uint),
    .tts_gray_o       (tts_gray),
    .st_byte_valid_o  (st_byte_valid),
    .st_byte_o        (st_byte),
    .st_byte_first_o  (st_byte_first),
    .st_byte_last_o   (st_byte_last)
  );

  always #(CLK_PERIOD / 2) dev_st_clk = ~dev_st_clk;

  always @(posedge dev_st_clk) begin
    cyc   <= cyc + 1;
    rst_q <= sys_reset_in;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h80200003;  // galois taps
    return n;
  endfunction

  function automatic logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] gray_ref(
    input logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] b
  );
    logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] g;
    g[dev_st_pkg::HDR_TTS_WIDTH-1] = b[dev_st_pkg::HDR_TTS_WIDTH-1];
    for (int i = 0; i < dev_st_pkg::HDR_TTS_WIDTH - 1; i++) g[i] = b[i + 1] ^ b[i];
    return g;
  endfunction

  function automatic dev_st_pkg::link_st_t link_ref(input logic rdy, input logic g1,
                                                    input logic m100);
    if (!rdy) return dev_st_pkg::LINK_DOWN;
    if (g1) return dev_st_pkg::LINK_1G;
    if (m100) return dev_st_pkg::LINK_100M;
    return dev_st_pkg::LINK_OTHER;
  endfunction

  function automatic dev_st_pkg::st_record_u expected_record(
    input logic [dev_st_pkg::SN_WIDTH-1:0] sn, input logic [dev_st_pkg::TTS_WIDTH-1:0] ts
  );
    dev_st_pkg::st_record_u r;
    r = '0;  // pads and replay info stay zero
    r.fields.rec_length     = 16'd48;
    r.fields.version        = 16'h0001;
    r.fields.dev_sn         = sn;
    r.fields.hdr_tts_length = 8'd7;
    r.fields.tts            = ts;
    return r;
  endfunction

  // --------------------
  // compare tasks
  // --------------------
  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_tts(input string name, input logic [dev_st_pkg::TTS_WIDTH-1:0] exp,
                           input logic [dev_st_pkg::TTS_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_gray(input string name,
                            input logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] exp,
                            input logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_link(input string name, input dev_st_pkg::link_st_t exp,
                            input dev_st_pkg::link_st_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [dev_st_pkg::BYTE_WIDTH-1:0] exp,
                            input logic [dev_st_pkg::BYTE_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};  // one step per bit
    end
  endtask

  // waits for the next first byte and checks its distance from mark
  task automatic wait_first_byte(input string name, input int lo, input int hi,
                                 input logic cap_low);
    int lat;
    do begin
      @(negedge dev_st_clk);
      if (!st_byte_first && cap_low) check_bit({name, " gate"}, 1'b0, capture_en);
      if (!st_byte_first && cyc - mark > hi) begin
        $display("%s: no record within %0d cycles", name, hi);
        abort_run();
      end
    end while (!st_byte_first);
    lat = cyc - mark;
    if (lat < lo || lat > hi) begin
      $display("%s: record started after %0d cycles, allowed %0d to %0d", name, lat, lo, hi);
      abort_run();
    end
    mark = cyc;
  endtask

  task automatic link_record(input string name, input logic [1:0] rdy);
    logic [63:0] r;
    take_bits(4, r);
    link_ready = rdy;
    link_1g    = r[1:0];
    link_100m  = r[3:2];
    mark = cyc;
    wait_first_byte(name, dev_st_pkg::ST_DELAY_CNT + 3, dev_st_pkg::ST_DELAY_CNT + 5, 1'b1);
    @(negedge dev_st_clk);
    check_bit({name, " gate"}, |rdy, capture_en);  // open only with a link up
  endtask

  // --------------------
  // monitors
  // --------------------
  always @(negedge dev_st_clk) begin
    if (!rst_q) begin
      check_tts("timestamp step", prev_tts + 64'd1, tts_uint);
      check_gray("timestamp gray", gray_ref(prev_tts[dev_st_pkg::HDR_TTS_WIDTH-1:0]), tts_gray);
    end
    prev_tts = tts_uint;
  end

  always @(negedge dev_st_clk) begin
    dev_st_pkg::st_record_u exp_rec;
    if (st_byte_valid) begin
      check_bit("first mark", rec_idx == 0, st_byte_first);
      check_bit("last mark", rec_idx == dev_st_pkg::ST_REC_LENGTH - 1, st_byte_last);
      if (rec_idx == 0) rec_tts = tts_uint - 64'd1;  // snapshot came a cycle earlier
      got_rec.bytes[dev_st_pkg::ST_REC_LENGTH - 1 - rec_idx] = st_byte;
      rec_idx++;
      if (rec_idx == dev_st_pkg::ST_REC_LENGTH) begin
        exp_rec = expected_record(dev_sn, rec_tts);
        for (int i = 0; i < dev_st_pkg::ST_REC_LENGTH; i++) begin
          check_byte($sformatf("record byte %0d", i), exp_rec.bytes[i], got_rec.bytes[i]);
        end
        rec_idx = 0;
        rec_count++;
      end
    end else if (rec_idx != 0) begin
      $display("record stream broke off after %0d bytes", rec_idx);
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: run still going after %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  // --------------------
  // stimulus
  // --------------------
  initial begin
    logic [63:0] r;
    dev_st_clk     = 1'b0;
    sys_reset_in   = 1'b1;
    cfg_capture_en = 1'b1;
    mg_join        = 1'b0;
    force_resend   = 1'b0;
    link_ready     = '0;
    link_1g        = '0;
    link_100m      = '0;
    cyc       = 0;
    rec_count = 0;
    rec_idx   = 0;
    lfsr      = 32'hf60b;
    take_bits(dev_st_pkg::SN_WIDTH, r);
    dev_sn = r;
    repeat (RESET_CYCLES) @(negedge dev_st_clk);
    sys_reset_in = 1'b0;

    repeat (ENC_CYCLES) begin
      @(negedge dev_st_clk);
      take_bits(6, r);
      link_ready = r[1:0];
      link_1g    = r[3:2];
      link_100m  = r[5:4];
      #1;
      for (int p = 0; p < dev_st_pkg::PHY_COUNT; p++) begin
        check_link("link encoding", link_ref(link_ready[p], link_1g[p], link_100m[p]),
                   link_st[p]);
      end
    end

    @(negedge dev_st_clk);
    link_ready = '0;  // all down, capture must stay shut
    mark = cyc;
    wait_first_byte("first record", 1, dev_st_pkg::ST_INTERVAL_CNT + 8, 1'b1);
    wait_first_byte("periodic interval", dev_st_pkg::ST_INTERVAL_CNT + 1,
                    dev_st_pkg::ST_INTERVAL_CNT + 1, 1'b1);
    repeat (GAP_CYCLES) @(negedge dev_st_clk);
    link_record("link up", 2'b01);
    link_record("link down", 2'b00);
    link_record("link toggle", 2'b10);

    repeat (GAP_CYCLES) @(negedge dev_st_clk);
    mark = cyc;
    mg_join = 1'b1;
    repeat (2) @(negedge dev_st_clk);
    mg_join = 1'b0;
    wait_first_byte("join", 4, 4, 1'b0);

    @(negedge dev_st_clk);
    cfg_capture_en = 1'b0;  // config alone shuts capture
    @(negedge dev_st_clk);
    check_bit("capture config off", 1'b0, capture_en);
    cfg_capture_en = 1'b1;

    repeat (GAP_CYCLES) @(negedge dev_st_clk);
    mark = cyc;
    force_resend = 1'b1;
    @(negedge dev_st_clk);
    force_resend = 1'b0;
    wait_first_byte("forced resend", dev_st_pkg::ST_FORCE_CNT + 1,
                    dev_st_pkg::ST_FORCE_CNT + 3, 1'b0);
    wait_first_byte("interval after force", dev_st_pkg::ST_INTERVAL_CNT + 1,
                    dev_st_pkg::ST_INTERVAL_CNT + 1, 1'b0);
    repeat (GAP_CYCLES) @(negedge dev_st_clk);

    if (rec_count != REC_COUNT) begin
      $display("expected %0d records, monitor saw %0d", REC_COUNT, rec_count);
      abort_run();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/dev_status_top.sv
`timescale 1ns/1ps
`default_nettype none

module dev_status_top (
  input  wire                                   dev_st_clk,
  input  wire                                   sys_reset_in,
  input  wire  [dev_st_pkg::SN_WIDTH-1:0]       dev_sn_i,
  input  wire                                   cfg_capture_en_i,
  input  wire                                   mg_join_i,
  input  wire                                   force_resend_i,
  input  wire  [dev_st_pkg::PHY_COUNT-1:0]      link_ready_i,
  input  wire  [dev_st_pkg::PHY_COUNT-1:0]      link_1g_i,
  input  wire  [dev_st_pkg::PHY_COUNT-1:0]      link_100m_i,
  output dev_st_pkg::link_st_t [dev_st_pkg::PHY_COUNT-1:0] link_st_o,
  output wire                                   capture_en_o,
  output wire  [dev_st_pkg::TTS_WIDTH-1:0]      tts_uint_o,
  output wire  [dev_st_pkg::HDR_TTS_WIDTH-1:0]  tts_gray_o,
  output wire                                   st_byte_valid_o,
  output wire  [dev_st_pkg::BYTE_WIDTH-1:0]     st_byte_o,
  output wire                                   st_byte_first_o,
  output wire                                   st_byte_last_o
);

  wire link_change;
  wire any_link;
  wire send;  // one-cycle record request

  // --------------------
  // timestamp
  // --------------------
  tts_counter u_tts (
    .dev_st_clk   (dev_st_clk),
    .sys_reset_in (sys_reset_in),
    .tts_uint_o   (tts_uint_o),
    .tts_gray_o   (tts_gray_o)
  );

  link_status_monitor u_link (
    .dev_st_clk    (dev_st_clk),
    .sys_reset_in  (sys_reset_in),
    .link_ready_i  (link_ready_i),
    .link_1g_i     (link_1g_i),
    .link_100m_i   (link_100m_i),
    .link_st_o     (link_st_o),
    .link_change_o (link_change),
    .any_link_o    (any_link)
  );

  // --------------------
  // status announcements
  // --------------------
  status_scheduler u_sched (
    .dev_st_clk       (dev_st_clk),
    .sys_reset_in     (sys_reset_in),
    .link_change_i    (link_change),
    .any_link_i       (any_link),
    .mg_join_i        (mg_join_i),
    .force_resend_i   (force_resend_i),
    .cfg_capture_en_i (cfg_capture_en_i),
    .send_o           (send),
    .capture_en_o     (capture_en_o)
  );

  status_record_tx u_rec_tx (
    .dev_st_clk      (dev_st_clk),
    .sys_reset_in    (sys_reset_in),
    .send_i          (send),
    .dev_sn_i        (dev_sn_i),
    .tts_uint_i      (tts_uint_o),
    .st_byte_valid_o (st_byte_valid_o),
    .st_byte_o       (st_byte_o),
    .st_byte_first_o (st_byte_first_o),
    .st_byte_last_o  (st_byte_last_o)
  );

endmodule

`default_nettype wire

// File: logic/status_record_tx.sv
`timescale 1ns/1ps
`default_nettype none

module status_record_tx (
  input  wire                                   dev_st_clk,
  input  wire                                   sys_reset_in,
  input  wire                                   send_i,
  input  wire  [dev_st_pkg::SN_WIDTH-1:0]       dev_sn_i,
  input  wire  [dev_st_pkg::TTS_WIDTH-1:0]      tts_uint_i,
  output logic                                  st_byte_valid_o,
  output logic [dev_st_pkg::BYTE_WIDTH-1:0]     st_byte_o,
  output logic                                  st_byte_first_o,
  output logic                                  st_byte_last_o
);

  dev_st_pkg::st_record_u                rec_q;     // snapshot being sent
  logic                                  busy;
  logic [dev_st_pkg::ST_IDX_WIDTH-1:0]   byte_idx;  // counts down, msb byte first

  // --------------------
  // record snapshot
  // --------------------
  always_ff @(posedge dev_st_clk) begin
    if (send_i && !busy) begin
      rec_q.fields.rec_length     <= 16'(dev_st_pkg::ST_REC_LENGTH);
      rec_q.fields.version        <= dev_st_pkg::ST_VERSION;
      rec_q.fields.dev_sn         <= dev_sn_i;
      rec_q.fields.pad0           <= '0;
      rec_q.fields.hdr_tts_length <= 8'(dev_st_pkg::HDR_TTS_LENGTH);
      rec_q.fields.replay_info    <= '0;
      rec_q.fields.pad1           <= '0;
      rec_q.fields.tts            <= tts_uint_i;  // value in the send cycle
      rec_q.fields.pad2           <= '0;
    end
  end

  // --------------------
  // byte serializer
  // --------------------
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      busy     <= 1'b0;
      byte_idx <= '0;
    end else if (!busy) begin
      if (send_i) begin
        busy     <= 1'b1;
        byte_idx <= dev_st_pkg::ST_IDX_WIDTH'(dev_st_pkg::ST_REC_LENGTH - 1);
      end
    end else begin
      if (byte_idx == '0) begin
        busy <= 1'b0;  // last byte out this cycle
      end
      byte_idx <= byte_idx - 1'b1;
    end
  end

  assign st_byte_valid_o = busy;
  assign st_byte_o       = rec_q.bytes[byte_idx];
  assign st_byte_first_o = busy &&
    (byte_idx == dev_st_pkg::ST_IDX_WIDTH'(dev_st_pkg::ST_REC_LENGTH - 1));
  assign st_byte_last_o  = busy && (byte_idx == '0);

  a_marks_need_valid: assert property (
    @(posedge dev_st_clk) disable iff (sys_reset_in)
    (st_byte_first_o || st_byte_last_o) |-> st_byte_valid_o
  ) else $error("first or last marked without valid");

endmodule

`default_nettype wire

// File: logic/status_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module status_scheduler (
  input  wire   dev_st_clk,
  input  wire   sys_reset_in,
  input  wire   link_change_i,
  input  wire   any_link_i,
  input  wire   mg_join_i,         // async level, >= 2 clocks wide
  input  wire   force_resend_i,
  input  wire   cfg_capture_en_i,
  output logic  send_o,
  output logic  capture_en_o
);

  logic [dev_st_pkg::ST_CNT_WIDTH-1:0] st_cnt;
  logic join_meta;
  logic join_sync;
  logic join_sync_q;
  logic join_rise;
  logic send_next;
  logic info_sent;

  // --------------------
  // join synchronizer
  // --------------------
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      join_meta   <= 1'b0;
      join_sync   <= 1'b0;
      join_sync_q <= 1'b0;
    end else begin
      join_meta   <= mg_join_i;
      join_sync   <= join_meta;
      join_sync_q <= join_sync;  // for edge detect
    end
  end

  assign join_rise = join_sync & ~join_sync_q;

  // timer expiry or join, never two sends back to back
  assign send_next = ((st_cnt == '0) | join_rise) & ~send_o;

  // --------------------
  // resend timer
  // --------------------
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      send_o <= 1'b0;
      st_cnt <= dev_st_pkg::ST_CNT_WIDTH'(dev_st_pkg::ST_INTERVAL_CNT);
    end else begin
      send_o <= send_next;
      if (send_next) begin
        st_cnt <= dev_st_pkg::ST_CNT_WIDTH'(dev_st_pkg::ST_INTERVAL_CNT);
      end else if (force_resend_i) begin
        st_cnt <= dev_st_pkg::ST_CNT_WIDTH'(dev_st_pkg::ST_FORCE_CNT);  // wins over link change
      end else if (link_change_i) begin
        st_cnt <= dev_st_pkg::ST_CNT_WIDTH'(dev_st_pkg::ST_DELAY_CNT);
      end else begin
        st_cnt <= st_cnt - 1'b1;
      end
    end
  end

  // capture stays off until a record went out with a link up
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in || !any_link_i) begin
      info_sent <= 1'b0;
    end else if (send_o) begin
      info_sent <= 1'b1;
    end
  end

  assign capture_en_o = cfg_capture_en_i & info_sent;

  a_send_single: assert property (
    @(posedge dev_st_clk) disable iff (sys_reset_in)
    send_o |=> !send_o
  ) else $error("send strobe held for two cycles");

endmodule

`default_nettype wire

// File: logic/link_status_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module link_status_monitor (
  input  wire                                   dev_st_clk,
  input  wire                                   sys_reset_in,
  input  wire  [dev_st_pkg::PHY_COUNT-1:0]      link_ready_i,
  input  wire  [dev_st_pkg::PHY_COUNT-1:0]      link_1g_i,
  input  wire  [dev_st_pkg::PHY_COUNT-1:0]      link_100m_i,
  output dev_st_pkg::link_st_t [dev_st_pkg::PHY_COUNT-1:0] link_st_o,
  output logic                                  link_change_o,
  output logic                                  any_link_o
);

  logic [dev_st_pkg::PHY_COUNT-1:0] ready_q;  // last seen ready vector

  // --------------------
  // per-phy encoding
  // --------------------
  for (genvar i = 0; i < dev_st_pkg::PHY_COUNT; i++) begin : g_phy
    assign link_st_o[i] = !link_ready_i[i] ? dev_st_pkg::LINK_DOWN
                        : link_1g_i[i]     ? dev_st_pkg::LINK_1G
                        : link_100m_i[i]   ? dev_st_pkg::LINK_100M
                        :                    dev_st_pkg::LINK_OTHER;

    a_down_iff_not_ready: assert property (
      @(posedge dev_st_clk) disable iff (sys_reset_in)
      (link_st_o[i] == dev_st_pkg::LINK_DOWN) == !link_ready_i[i]
    ) else $error("phy %0d link state disagrees with ready", i);
  end

  assign any_link_o = |link_ready_i;

  // strobe one cycle after any phy goes up or down
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      ready_q       <= '0;
      link_change_o <= 1'b0;
    end else begin
      ready_q       <= link_ready_i;
      link_change_o <= (ready_q != link_ready_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/tts_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tts_counter (
  input  wire                                  dev_st_clk,
  input  wire                                  sys_reset_in,
  output logic [dev_st_pkg::TTS_WIDTH-1:0]     tts_uint_o,
  output logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] tts_gray_o
);

  function automatic logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] bin2gray(
    input logic [dev_st_pkg::HDR_TTS_WIDTH-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      tts_uint_o <= '0;
      tts_gray_o <= '0;
    end else begin
      tts_uint_o <= tts_uint_o + 1'b1;
      // gray copy lags the binary count by one cycle
      tts_gray_o <= bin2gray(tts_uint_o[dev_st_pkg::HDR_TTS_WIDTH-1:0]);
    end
  end

  // --------------------
  // checks
  // --------------------
  a_tts_step: assert property (
    @(posedge dev_st_clk) disable iff (sys_reset_in)
    !$past(sys_reset_in) |-> tts_uint_o == $past(tts_uint_o) + 1'b1
  ) else $error("timestamp did not step by one");

endmodule

`default_nettype wire

// File: logic/dev_st_pkg.sv
`default_nettype none

package dev_st_pkg;

  // --------------------
  // widths and counts
  // --------------------
  localparam int BYTE_WIDTH     = 8;
  localparam int PHY_COUNT      = 2;   // copper phys

  localparam int TTS_LENGTH     = 8;   // running timestamp, reveals restarts
  localparam int TTS_WIDTH      = TTS_LENGTH * BYTE_WIDTH;
  localparam int HDR_TTS_LENGTH = 7;   // part carried in capture headers
  localparam int HDR_TTS_WIDTH  = HDR_TTS_LENGTH * BYTE_WIDTH;

  localparam int SN_LENGTH      = 8;
  localparam int SN_WIDTH       = SN_LENGTH * BYTE_WIDTH;

  localparam int ST_REC_LENGTH  = 48;  // status record bytes
  localparam int ST_REC_WIDTH   = ST_REC_LENGTH * BYTE_WIDTH;
  localparam int ST_IDX_WIDTH   = $clog2(ST_REC_LENGTH);
  localparam logic [2*BYTE_WIDTH-1:0] ST_VERSION = 16'h0001;

  // --------------------
  // resend timer, scaled for sim
  // --------------------
  localparam int ST_INTERVAL_CNT = 300;  // periodic
  localparam int ST_DELAY_CNT    = 60;   // after link change
  localparam int ST_FORCE_CNT    = 50;   // after forced resend, >= record length
  localparam int ST_CNT_WIDTH    = $clog2(ST_INTERVAL_CNT);

  // per-phy link state as reported on the board pins
  typedef enum logic [1:0] {
    LINK_DOWN  = 2'b00,
    LINK_100M  = 2'b01,
    LINK_1G    = 2'b10,
    LINK_OTHER = 2'b11  // 10M or unknown speed
  } link_st_t;

  // status record, msb first on the wire
  typedef struct packed {
    logic [2*BYTE_WIDTH-1:0]          rec_length;      // always 48
    logic [2*BYTE_WIDTH-1:0]          version;
    logic [SN_WIDTH-1:0]              dev_sn;
    logic [4*BYTE_WIDTH-1:0]          pad0;            // closes first 16 bytes
    logic [BYTE_WIDTH-1:0]            hdr_tts_length;  // always 7
    logic [4*BYTE_WIDTH-1:0]          replay_info;     // no replay buffer, zero
    logic [11*BYTE_WIDTH-1:0]         pad1;
    logic [TTS_WIDTH-1:0]             tts;
    logic [(16-TTS_LENGTH)*BYTE_WIDTH-1:0] pad2;
  } st_record_t;

  // same 48 bytes, built by field and shifted out by byte
  typedef union packed {
    st_record_t                                  fields;
    logic [ST_REC_LENGTH-1:0][BYTE_WIDTH-1:0]    bytes;
  } st_record_u;

endpackage

`default_nettype wire
